// File: common/zx_bus_pkg.sv
/*
 * Shared definitions for the ZX Spectrum paging and ULA port logic:
 * machine model enum, bus data types and fixed constants
 */

`default_nettype none

package zx_bus_pkg;

	// ========================================================================
	// Machine model
	// ========================================================================

	// Sampled while reset is high; code 3 is treated as 48K
	typedef enum logic [1:0] {
		model_48k   = 2'd0,
		model_128k  = 2'd1,
		model_plus3 = 2'd2
	} model_t;

	// ========================================================================
	// Bus types
	// ========================================================================

	// Z80 address bus
	typedef logic [15:0] cpu_addr_t;

	typedef logic [7:0] byte_t;

	// Physical memory address
	// ROM: tag in 20:18, page in 17:14; RAM: bank in 16:14
	typedef logic [20:0] ram_addr_t;

	typedef logic [3:0] rom_page_t;

	// ========================================================================
	// Constants
	// ========================================================================

	// ROM region tag in the upper address bits
	localparam logic [2:0] rom_base_default = 3'b101;

	// Floating bus value for unmapped port reads
	localparam byte_t idle_read = 8'hFF;

endpackage

`default_nettype wire

// File: hdl/page_regs.sv
/*
 * 128K (7FFD) and +3 (1FFD) paging registers with lock bit,
 * and the machine model latched during reset
 */

`timescale 1ns/1ps
`default_nettype none

module page_regs import zx_bus_pkg::*; (
	input  wire       clk_sys,
	input  wire       reset,
	input  model_t    model,
	input  cpu_addr_t cpu_addr,
	input  byte_t     cpu_dout,
	input  wire       io_wr,
	output byte_t     page_reg,
	output byte_t     page_reg_plus3,
	output logic      plus3,
	output logic      zx48
);

	// ========================================================================
	// Machine model
	// ========================================================================

	model_t model_q;

	// Follows the model input for as long as reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			case (model)
				model_128k:  model_q <= model_128k;
				model_plus3: model_q <= model_plus3;
				default:     model_q <= model_48k;
			endcase
		end
	end

	assign zx48  = (model_q == model_48k);
	assign plus3 = (model_q == model_plus3);

	// ========================================================================
	// Port decode
	// ========================================================================

	logic page_disable;
	logic page_write;
	logic page_write_plus3;

	// Bit 5 of 7FFD locks paging until the next reset
	assign page_disable = zx48 | page_reg[5];

	// 7FFD, partial decode; on +3 bit 14 must be set too
	assign page_write = io_wr
		& ~cpu_addr[15]
		& ~cpu_addr[1]
		& (cpu_addr[14] | ~plus3)
		& ~page_disable;

	// 1FFD exists on +3 only
	assign page_write_plus3 = io_wr
		& plus3
		& ~cpu_addr[15]
		& ~cpu_addr[14]
		& ~cpu_addr[13]
		& cpu_addr[12]
		& ~cpu_addr[1]
		& ~page_disable;

	// ========================================================================
	// Registers
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg       <= '0;
			page_reg_plus3 <= '0;
		end else if (page_write) begin
			page_reg <= cpu_dout;
		end else if (page_write_plus3) begin
			page_reg_plus3 <= cpu_dout;
		end
	end

endmodule

`default_nettype wire

// File: hdl/ula_port.sv
/*
 * ULA port FE: border, EAR and MIC latches, and the read value
 * built from keyboard columns and tape input
 */

`timescale 1ns/1ps
`default_nettype none

module ula_port import zx_bus_pkg::*; (
	input  wire        clk_sys,
	input  wire        reset,
	input  cpu_addr_t  cpu_addr,
	input  byte_t      cpu_dout,
	input  wire        io_wr,
	input  wire  [4:0] key_cols,
	input  wire        tape_in,
	output logic [2:0] border,
	output logic       ear_out,
	output logic       mic_out,
	output byte_t      fe_read
);

	logic ula_we;

	// ULA answers any even port address
	assign ula_we = io_wr & ~cpu_addr[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border  <= '0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (ula_we) begin
			border  <= cpu_dout[2:0];
			ear_out <= cpu_dout[4];
			mic_out <= cpu_dout[3];
		end
	end

	// Bits 7 and 5 float high, bit 6 is EAR in
	// Key columns are active low
	assign fe_read = {1'b1, ~tape_in, 1'b1, key_cols};

endmodule

`default_nettype wire

// File: hdl/bus_mapper.sv
/*
 * CPU address to RAM/ROM address mapping, ROM write protection
 * and CPU read-data selection
 */

`timescale 1ns/1ps
`default_nettype none

module bus_mapper import zx_bus_pkg::*; #(
	parameter logic [2:0] rom_base = rom_base_default
) (
	input  cpu_addr_t cpu_addr,
	input  byte_t     cpu_dout,
	input  wire       mem_wr,
	input  wire       mem_rd,
	input  wire       io_rd,
	input  byte_t     page_reg,
	input  byte_t     page_reg_plus3,
	input  wire       plus3,
	input  wire       zx48,
	input  byte_t     fe_read,
	input  byte_t     ram_dout,
	output ram_addr_t ram_addr,
	output logic      ram_we,
	output byte_t     cpu_din
);

	logic        page_special;
	logic [1:0]  quarter;
	logic [13:0] offset;
	logic [1:0]  layout;
	rom_page_t   page_rom;
	logic [2:0]  bank;
	logic        rom_sel;

	// All-RAM modes of the +3
	assign page_special = page_reg_plus3[0];
	assign layout       = page_reg_plus3[2:1];

	assign quarter = cpu_addr[15:14];
	assign offset  = cpu_addr[13:0];

	// ========================================================================
	// ROM page
	// ========================================================================

	// 48K ROM sits at page 7 of the 128K ROM set
	always_comb begin
		if (zx48) begin
			page_rom = 4'b0111;
		end else if (plus3) begin
			page_rom = {2'b10, page_reg_plus3[2], page_reg[4]};
		end else begin
			page_rom = {3'b011, page_reg[4]};
		end
	end

	// ========================================================================
	// RAM bank
	// ========================================================================

	always_comb begin
		if (page_special) begin
			case ({layout, quarter})
				4'b00_00: bank = 3'd0;
				4'b00_01: bank = 3'd1;
				4'b00_10: bank = 3'd2;
				4'b00_11: bank = 3'd3;
				4'b01_00: bank = 3'd4;
				4'b01_01: bank = 3'd5;
				4'b01_10: bank = 3'd6;
				4'b01_11: bank = 3'd7;
				4'b10_00: bank = 3'd4;
				4'b10_01: bank = 3'd5;
				4'b10_10: bank = 3'd6;
				4'b10_11: bank = 3'd3;
				4'b11_00: bank = 3'd4;
				4'b11_01: bank = 3'd7;
				4'b11_10: bank = 3'd6;
				default:  bank = 3'd3;
			endcase
		end else begin
			// Quarter 0 is ROM, bank value unused there
			case (quarter)
				2'd1:    bank = 3'd5;
				2'd2:    bank = 3'd2;
				2'd3:    bank = page_reg[2:0];
				default: bank = 3'd0;
			endcase
		end
	end

	// ========================================================================
	// Address, write enable and read data
	// ========================================================================

	assign rom_sel = ~page_special & (quarter == 2'd0);

	always_comb begin
		if (rom_sel) begin
			ram_addr = {rom_base, page_rom, offset};
		end else begin
			ram_addr = {4'b0000, bank, offset};
		end
	end

	// ROM is read only
	assign ram_we = mem_wr & ~rom_sel;

	always_comb begin
		if (mem_rd) begin
			cpu_din = ram_dout;
		end else if (io_rd & ~cpu_addr[0]) begin
			cpu_din = fe_read;
		end else begin
			cpu_din = idle_read;
		end
	end

endmodule

`default_nettype wire

// File: hdl/zx_bus_top.sv
/*
 * Top level: paging registers, ULA port and bus mapper
 */

`timescale 1ns/1ps
`default_nettype none

module zx_bus_top import zx_bus_pkg::*; #(
	parameter logic [2:0] rom_base = rom_base_default
) (
	input  wire        clk_sys,
	input  wire        reset,
	input  cpu_addr_t  cpu_addr,
	input  byte_t      cpu_dout,
	input  wire        io_wr,
	input  wire        io_rd,
	input  wire        mem_wr,
	input  wire        mem_rd,
	input  model_t     model,
	input  wire  [4:0] key_cols,
	input  wire        tape_in,
	input  byte_t      ram_dout,
	output logic [2:0] border,
	output logic       ear_out,
	output logic       mic_out,
	output ram_addr_t  ram_addr,
	output logic       ram_we,
	output byte_t      cpu_din
);

	byte_t page_reg;
	byte_t page_reg_plus3;
	logic  plus3;
	logic  zx48;
	byte_t fe_read;

	page_regs i_page_regs (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.model          (model),
		.cpu_addr       (cpu_addr),
		.cpu_dout       (cpu_dout),
		.io_wr          (io_wr),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.plus3          (plus3),
		.zx48           (zx48)
	);

	ula_port i_ula_port (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.io_wr    (io_wr),
		.key_cols (key_cols),
		.tape_in  (tape_in),
		.border   (border),
		.ear_out  (ear_out),
		.mic_out  (mic_out),
		.fe_read  (fe_read)
	);

	bus_mapper #(
		.rom_base (rom_base)
	) i_bus_mapper (
		.cpu_addr       (cpu_addr),
		.cpu_dout       (cpu_dout),
		.mem_wr         (mem_wr),
		.mem_rd         (mem_rd),
		.io_rd          (io_rd),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.plus3          (plus3),
		.zx48           (zx48),
		.fe_read        (fe_read),
		.ram_dout       (ram_dout),
		.ram_addr       (ram_addr),
		.ram_we         (ram_we),
		.cpu_din        (cpu_din)
	);

endmodule

`default_nettype wire

// File: sim/zx_bus_checker.sv
/*
 * Concurrent assertions on the bus strobes, ROM write protection
 * and the ULA output latches
 */

`timescale 1ns/1ps
`default_nettype none

module zx_bus_checker import zx_bus_pkg::*; (
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        io_wr,
	input  wire        io_rd,
	input  wire        mem_wr,
	input  wire        mem_rd,
	input  cpu_addr_t  cpu_addr,
	input  byte_t      page_reg_plus3,
	input  wire        ram_we,
	input  wire  [2:0] border,
	input  wire        ear_out,
	input  wire        mic_out
);

	// ========================================================================
	// Bus protocol
	// ========================================================================

	one_strobe: assert property (
		@(posedge clk_sys) disable iff (reset)
		$onehot0({io_wr, io_rd, mem_wr, mem_rd})
	) else $error("More than one bus strobe high in the same cycle");

	// ========================================================================
	// Memory and ULA
	// ========================================================================

	// Quarter 0 is ROM unless the +3 all-RAM mode is on
	rom_protect: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(ram_we && !page_reg_plus3[0] && cpu_addr[15:14] == 2'b00)
	) else $error("Write enable raised for ROM in quarter 0");

	ula_hold: assert property (
		@(posedge clk_sys) disable iff (reset)
		!$past(io_wr) |-> ($stable(border) && $stable(ear_out) && $stable(mic_out))
	) else $error("ULA outputs changed without a port write in the cycle before");

endmodule

`default_nettype wire

// File: sim/zx_bus_tb.sv
/*
 * Testbench for zx_bus_top: clock, reset per model, LFSR stimulus,
 * shadow model of the port registers, per-test reports and timeout
 */

`timescale 1ns/1ps
`default_nettype none

module zx_bus_tb import zx_bus_pkg::*; ();

	localparam logic [2:0] tag_rom    = 3'b101;
	localparam int         max_cycles = 4000;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        io_wr;
	logic        io_rd;
	logic        mem_wr;
	logic        mem_rd;
	model_t      model;
	logic [4:0]  key_cols;
	logic        tape_in;
	logic [7:0]  ram_dout;
	wire  [2:0]  border;
	wire         ear_out;
	wire         mic_out;
	wire         ram_we;
	wire  [20:0] ram_addr;
	wire  [7:0]  cpu_din;

	// Shadow of the DUT state, kept from the port rules
	model_t      exp_model;
	logic [7:0]  exp_page;
	logic [7:0]  exp_p3;
	logic [2:0]  exp_border;
	logic        exp_ear;
	logic        exp_mic;

	logic [31:0] lfsr_state = 32'h118e05cb;
	int          cycle_count = 0;
	int          test_errors = 0;
	int          pass_count = 0;
	int          fail_count = 0;

	zx_bus_top i_zx_bus_top (
		.clk_sys(clk_sys), .reset(reset), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
		.io_wr(io_wr), .io_rd(io_rd), .mem_wr(mem_wr), .mem_rd(mem_rd),
		.model(model), .key_cols(key_cols), .tape_in(tape_in), .ram_dout(ram_dout),
		.border(border), .ear_out(ear_out), .mic_out(mic_out),
		.ram_addr(ram_addr), .ram_we(ram_we), .cpu_din(cpu_din)
	);

	bind zx_bus_top zx_bus_checker i_zx_bus_checker (
		.clk_sys(clk_sys), .reset(reset), .io_wr(io_wr), .io_rd(io_rd),
		.mem_wr(mem_wr), .mem_rd(mem_rd), .cpu_addr(cpu_addr),
		.page_reg_plus3(page_reg_plus3), .ram_we(ram_we),
		.border(border), .ear_out(ear_out), .mic_out(mic_out)
	);

	always #5 clk_sys = ~clk_sys;

	// Tests take about 2000 cycles
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Galois LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
			else
				lfsr_state = lfsr_state >> 1;
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	// ========================================================================
	// Expected values
	// ========================================================================

	function automatic logic [20:0] expected_addr(input logic [15:0] a);
		logic [11:0] banks;
		logic [3:0]  rom_page;
		logic [1:0]  q;
		q = a[15:14];
		if (exp_p3[0]) begin
			// Bank per quarter, quarter 0 in the low three bits
			case (exp_p3[2:1])
				2'd0:    banks = {3'd3, 3'd2, 3'd1, 3'd0};
				2'd1:    banks = {3'd7, 3'd6, 3'd5, 3'd4};
				2'd2:    banks = {3'd3, 3'd6, 3'd5, 3'd4};
				default: banks = {3'd3, 3'd6, 3'd7, 3'd4};
			endcase
			return {4'd0, banks[q * 3 +: 3], a[13:0]};
		end
		if (q == 2'd0) begin
			if (exp_model == model_48k)
				rom_page = 4'd7;
			else if (exp_model == model_128k)
				rom_page = 4'd6 + 4'(exp_page[4]);
			else
				rom_page = 4'd8 + 4'(exp_p3[2]) * 4'd2 + 4'(exp_page[4]);
			return {tag_rom, rom_page, a[13:0]};
		end
		if (q == 2'd1)
			return {4'd0, 3'd5, a[13:0]};
		if (q == 2'd2)
			return {4'd0, 3'd2, a[13:0]};
		return {4'd0, exp_page[2:0], a[13:0]};
	endfunction

	task automatic check_ula();
		check_value("border", border, exp_border);
		check_value("ear_out", ear_out, exp_ear);
		check_value("mic_out", mic_out, exp_mic);
	endtask

	// ========================================================================
	// Bus cycles
	// ========================================================================

	// Strobes as {io_wr, io_rd, mem_wr, mem_rd}; returns at the falling edge
	task automatic bus_cycle(input logic [15:0] a, input logic [7:0] d,
			input logic [3:0] strobes, input logic [7:0] ramd,
			input logic [4:0] keys, input logic t);
		@(posedge clk_sys);
		cpu_addr <= a;
		cpu_dout <= d;
		{io_wr, io_rd, mem_wr, mem_rd} <= strobes;
		ram_dout <= ramd;
		key_cols <= keys;
		tape_in  <= t;
		@(negedge clk_sys);
	endtask

	task automatic bus_idle();
		bus_cycle(16'h0000, 8'h00, 4'b0000, 8'h00, 5'h1F, 1'b0);
	endtask

	task automatic mem_access(input logic [15:0] a, input logic wr, input logic rd,
			input logic [7:0] ramd);
		bus_cycle(a, 8'h00, {2'b00, wr, rd}, ramd, 5'h1F, 1'b0);
		check_value("ram_addr", ram_addr, expected_addr(a));
		check_value("ram_we", ram_we, wr && !(a[15:14] == 2'b00 && !exp_p3[0]));
		if (rd)
			check_value("cpu_din", cpu_din, ramd);
	endtask

	// Old state must still show in the write cycle itself
	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		logic paging_on;
		logic hit_7ffd;
		logic hit_1ffd;
		paging_on = (exp_model != model_48k) && !exp_page[5];
		hit_7ffd  = paging_on && !a[15] && !a[1] && (a[14] || exp_model != model_plus3);
		hit_1ffd  = paging_on && exp_model == model_plus3
			&& a[15:12] == 4'b0001 && !a[1];
		bus_cycle(a, d, 4'b1000, 8'h00, 5'h1F, 1'b0);
		check_value("ram_addr", ram_addr, expected_addr(a));
		check_ula();
		if (hit_7ffd)
			exp_page = d;
		else if (hit_1ffd)
			exp_p3 = d;
		if (!a[0]) begin
			exp_border = d[2:0];
			exp_ear    = d[4];
			exp_mic    = d[3];
		end
	endtask

	task automatic io_read(input logic [15:0] a, input logic [4:0] keys, input logic t);
		logic [7:0] exp_din;
		exp_din = a[0] ? 8'hFF : (8'hA0 | (t ? 8'h00 : 8'h40) | {3'b000, keys});
		bus_cycle(a, 8'h00, 4'b0100, 8'h5A, keys, t);
		check_value("cpu_din", cpu_din, exp_din);
		check_value("ram_we", ram_we, 1'b0);
	endtask

	task automatic reset_with(input model_t m);
		@(posedge clk_sys);
		reset <= 1'b1;
		model <= m;
		{io_wr, io_rd, mem_wr, mem_rd} <= 4'b0000;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		exp_model  = m;
		exp_page   = 8'h00;
		exp_p3     = 8'h00;
		exp_border = 3'd0;
		exp_ear    = 1'b0;
		exp_mic    = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("%s: pass", name);
		end else begin
			fail_count++;
			$display("%s: fail, %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic fixed_map_48k();
		logic [31:0] r;
		reset_with(model_48k);
		repeat (300) begin
			r = rand_bits(17);
			mem_access(r[15:0], r[16], 1'b0, 8'h00);
		end
		// Nonzero bank so an accepted write would move quarter 3
		r = rand_bits(8);
		io_write(16'h7FFD, (r[7:0] & 8'hDF) | 8'h01);
		mem_access(16'h0123, 1'b1, 1'b0, 8'h00);
		mem_access(16'hC123, 1'b1, 1'b0, 8'h00);
		finish_test("48K model");
	endtask

	task automatic paging_128k();
		logic [31:0] r;
		reset_with(model_128k);
		repeat (100) begin
			r = rand_bits(8);
			io_write(16'h7FFD, r[7:0] & 8'hDF);
			r = rand_bits(14);
			mem_access({2'b11, r[13:0]}, 1'b1, 1'b0, 8'h00);
			mem_access({2'b00, r[13:0]}, 1'b0, 1'b1, 8'h00);
		end
		// Lock, then later writes must be ignored
		io_write(16'h7FFD, 8'h23);
		repeat (20) begin
			r = rand_bits(22);
			io_write(16'h7FFD, r[7:0]);
			mem_access({2'b11, r[21:8]}, 1'b0, 1'b1, 8'h00);
			mem_access({2'b00, r[21:8]}, 1'b0, 1'b1, 8'h00);
		end
		finish_test("128K paging");
	endtask

	task automatic special_plus3();
		logic [31:0] r;
		reset_with(model_plus3);
		for (int rom = 0; rom < 4; rom++) begin
			io_write(16'h7FFD, {3'b000, rom[0], 4'b0000});
			io_write(16'h1FFD, {5'b00000, rom[1], 2'b00});
			mem_access(16'h2ABC, 1'b1, 1'b0, 8'h00);
		end
		io_write(16'h3FFD, 8'h01);
		for (int lay = 0; lay < 4; lay++) begin
			io_write(16'h1FFD, {5'b00000, lay[1:0], 1'b1});
			for (int q = 0; q < 4; q++) begin
				r = rand_bits(14);
				mem_access({q[1:0], r[13:0]}, 1'b1, 1'b0, 8'h00);
			end
		end
		finish_test("+3 paging");
	endtask

	task automatic ula_port_writes();
		logic [31:0] a;
		logic [31:0] d;
		repeat (150) begin
			a = rand_bits(16);
			d = rand_bits(8);
			io_write({a[15:1], 1'b0}, d[7:0]);
			bus_idle();
			check_ula();
			io_write({a[15:1], 1'b1}, ~d[7:0]);
			bus_idle();
			check_ula();
		end
		finish_test("ULA port");
	endtask

	task automatic read_data();
		logic [31:0] a;
		logic [31:0] d;
		repeat (200) begin
			a = rand_bits(16);
			d = rand_bits(8);
			mem_access(a[15:0], 1'b0, 1'b1, d[7:0]);
			a = rand_bits(16);
			d = rand_bits(6);
			io_read({a[15:1], 1'b0}, d[4:0], d[5]);
			io_read({a[15:1], 1'b1}, d[4:0], d[5]);
		end
		bus_idle();
		check_value("cpu_din", cpu_din, 8'hFF);
		finish_test("Read data");
	endtask

	initial begin
		reset    = 1'b1;
		model    = model_48k;
		cpu_addr = 16'h0000;
		cpu_dout = 8'h00;
		io_wr    = 1'b0;
		io_rd    = 1'b0;
		mem_wr   = 1'b0;
		mem_rd   = 1'b0;
		key_cols = 5'h1F;
		tape_in  = 1'b0;
		ram_dout = 8'h00;
		fixed_map_48k();
		paging_128k();
		special_plus3();
		ula_port_writes();
		read_data();
		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
common/zx_bus_pkg.sv
hdl/page_regs.sv
hdl/ula_port.sv
hdl/bus_mapper.sv
hdl/zx_bus_top.sv
sim/zx_bus_checker.sv
sim/zx_bus_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = zx_bus_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
